// ==== sd_frame_pkg.sv ====
// one-bit SD data frame layout; no CRC, the 16-bit trailer is always zero
package sd_frame_pkg;

	// data frame: start, word, trailer, end
	localparam int frame_len = 50;
	localparam int data_w    = 32;
	localparam int trailer_w = 16;

	// status token from the card, start bit counted in
	localparam int resp_len = 3;

	// wide enough to count up to frame_len
	localparam int len_w = 6;

	// fields of a full data frame in order of arrival
	typedef struct packed {
		logic                 start_bit;
		logic [data_w-1:0]    data;
		logic [trailer_w-1:0] trailer;
		logic                 end_bit;
	} rx_data_t;

	// a token is shifted in from the right, upper bits stay zero
	typedef struct packed {
		logic [frame_len-resp_len-1:0] unused;
		logic [resp_len-1:0]           token;
	} rx_token_t;

	// same shift register, two readings
	typedef union packed {
		rx_data_t  blk;
		rx_token_t tok;
	} rx_frame_t;

endpackage

// ==== sd_ctrl_pkg.sv ====
// controller encodings; block count is 4 bits and timeout count 16 bits wide
package sd_ctrl_pkg;

	// block sequencing states
	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_send,
		st_wait_resp,
		st_recv,
		st_store,
		st_done
	} ctrl_state_t;

	// card accepted the block (start bit included)
	localparam logic [2:0] resp_accepted = 3'b010;

	localparam int blk_w     = 4;
	localparam int timeout_w = 16;

endpackage

// ==== dat_serializer.sv ====
// sends one 50-bit frame per load_send, MSB first; tx_bit idles at 1, drops load when disabled
`timescale 1ns/10ps

module dat_serializer
	import sd_frame_pkg::*;
(
	input  logic              sd_clock,
	input  logic              rst_n,
	input  logic              tx_enable,
	input  logic              load_send,
	input  logic [data_w-1:0] tx_word,
	output logic              tx_bit,
	output logic              tx_complete
);

	logic [frame_len-1:0] shift_q;
	logic [len_w-1:0]     cnt;
	logic                 busy;
	logic                 last_bit;

	// the 50th bit is on tx_bit this cycle
	assign last_bit    = busy && (cnt == len_w'(frame_len - 1));
	assign tx_complete = last_bit;

	// line stays high between frames
	assign tx_bit = busy ? shift_q[frame_len-1] : 1'b1;

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (!tx_enable) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (load_send) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (last_bit) begin
				busy <= 1'b0;
			end
		end
	end

	// frame body
	always_ff @(posedge sd_clock) begin
		if (tx_enable && load_send) begin
			shift_q <= {1'b0, tx_word, {trailer_w{1'b0}}, 1'b1};
		end else if (busy) begin
			shift_q <= {shift_q[frame_len-2:0], 1'b0};
		end
	end

endmodule

// ==== dat_deserializer.sv ====
// needs one high sample before a low start bit counts; output right-aligned, kept after done
`timescale 1ns/10ps

module dat_deserializer
	import sd_frame_pkg::*;
(
	input  logic      sd_clock,
	input  logic      rst_n,
	input  logic      rx_enable,
	input  logic      expect_resp,
	input  logic      rx_bit,
	output rx_frame_t rx_frame,
	output logic      rx_complete,
	output logic      start_seen
);

	logic [frame_len-1:0] shift_q;
	logic [len_w-1:0]     len;
	logic [len_w-1:0]     cnt;
	logic [len_w-1:0]     cnt_nxt;
	logic                 armed;
	logic                 busy;
	logic                 start_hit;

	// token or full data frame
	assign len     = expect_resp ? len_w'(resp_len) : len_w'(frame_len);
	assign cnt_nxt = cnt + 1'b1;

	// armed first, so the tail of our own outgoing frame in the sampler is ignored
	assign start_hit = armed && !busy && !rx_bit;

	assign rx_frame = shift_q;

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			armed       <= 1'b0;
			busy        <= 1'b0;
			cnt         <= '0;
			rx_complete <= 1'b0;
			start_seen  <= 1'b0;
		end else begin
			rx_complete <= 1'b0;
			start_seen  <= 1'b0;
			if (!rx_enable) begin
				armed <= 1'b0;
				busy  <= 1'b0;
				cnt   <= '0;
			end else if (busy) begin
				cnt <= cnt_nxt;
				if (cnt_nxt == len) begin
					busy        <= 1'b0;
					armed       <= 1'b0;
					rx_complete <= 1'b1;
				end
			end else if (start_hit) begin
				// start bit is bit one of the frame
				busy       <= 1'b1;
				cnt        <= len_w'(1);
				start_seen <= 1'b1;
			end else if (rx_bit) begin
				armed <= 1'b1;
			end
		end
	end

	always_ff @(posedge sd_clock) begin
		if (rx_enable) begin
			if (busy) begin
				shift_q <= {shift_q[frame_len-2:0], rx_bit};
			end else if (start_hit) begin
				shift_q <= '0;
			end
		end
	end

endmodule

// ==== dat_pad.sv ====
// data pin driver; needs an external pull-up, output and enable each one register late
`timescale 1ns/10ps

module dat_pad (
	input  logic sd_clock,
	input  logic rst_n,
	input  logic tx_bit,
	input  logic drive_pin,
	output logic rx_bit,
	inout  wire  dat_pin
);

	logic out_q;
	logic oe_q;
	logic sync1;
	logic sync2;

	always_ff @(posedge sd_clock) begin
		out_q <= tx_bit;
	end

	// enable and input sampler
	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			oe_q  <= 1'b0;
			sync1 <= 1'b1;
			sync2 <= 1'b1;
		end else begin
			oe_q  <= drive_pin;
			sync1 <= dat_pin;
			sync2 <= sync1;
		end
	end

	assign dat_pin = oe_q ? out_q : 1'bz;
	assign rx_bit  = sync2;

endmodule

// ==== dat_phys_controller.sv ====
// blocks=0 with multiple runs one block; idle_in drops a pending complete and timeout
`timescale 1ns/10ps

module dat_phys_controller
	import sd_frame_pkg::*, sd_ctrl_pkg::*;
(
	input  logic                 sd_clock,
	input  logic                 rst_n,
	input  logic                 strobe_in,
	input  logic                 ack_in,
	input  logic                 idle_in,
	input  logic [timeout_w-1:0] timeout_reg,
	input  logic [blk_w-1:0]     blocks,
	input  logic                 write_read,
	input  logic                 multiple,
	input  logic                 status,
	input  logic [data_w-1:0]    data_from_fifo,
	input  logic                 tx_complete,
	input  logic                 rx_complete,
	input  logic                 start_seen,
	input  rx_frame_t            rx_frame,
	output logic                 serial_ready,
	output logic                 complete,
	output logic                 ack_out,
	output logic                 data_timeout,
	output logic                 read_enable,
	output logic                 write_enable,
	output logic [data_w-1:0]    data_to_fifo,
	output logic                 load_send,
	output logic [data_w-1:0]    tx_word,
	output logic                 tx_enable,
	output logic                 rx_enable,
	output logic                 expect_resp,
	output logic                 drive_pin
);

	ctrl_state_t          state;
	logic [blk_w-1:0]     blk_left;
	logic [timeout_w-1:0] tmo_cnt;
	logic                 started;
	logic                 accept;
	logic                 waiting;
	logic                 timed_out;
	logic                 last_blk;

	assign accept    = (state == st_idle) && strobe_in && !idle_in;
	assign waiting   = (state == st_wait_resp) || (state == st_recv);
	assign timed_out = waiting && !started && (tmo_cnt == timeout_reg);
	assign last_blk  = (blk_left == blk_w'(1));

	// host side
	assign serial_ready = (state == st_idle);
	assign complete     = (state == st_done);

	// FIFO side, pop only with a word present
	assign read_enable  = (state == st_fetch) && status && !idle_in;
	assign write_enable = (state == st_store);
	assign data_to_fifo = rx_frame.blk.data;

	// link control
	assign tx_enable   = (state == st_send);
	assign drive_pin   = (state == st_send);
	assign rx_enable   = waiting;
	assign expect_resp = (state == st_wait_resp);

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			state        <= st_idle;
			ack_out      <= 1'b0;
			load_send    <= 1'b0;
			data_timeout <= 1'b0;
			blk_left     <= '0;
			tmo_cnt      <= '0;
			started      <= 1'b0;
		end else if (idle_in) begin
			// abort, back to idle at once
			state        <= st_idle;
			ack_out      <= 1'b0;
			load_send    <= 1'b0;
			data_timeout <= 1'b0;
			tmo_cnt      <= '0;
			started      <= 1'b0;
		end else begin
			ack_out   <= accept;
			load_send <= read_enable;

			// silence counter, frozen once a start bit arrives
			if (waiting && !started) begin
				tmo_cnt <= tmo_cnt + 1'b1;
			end else begin
				tmo_cnt <= '0;
			end
			if (start_seen) begin
				started <= 1'b1;
			end

			case (state)
				st_idle: begin
					if (strobe_in) begin
						blk_left <= (multiple && blocks != '0) ? blocks : blk_w'(1);
						state    <= write_read ? st_fetch : st_recv;
					end
				end
				st_fetch: begin
					// wait here while the FIFO is empty
					if (status) begin
						state <= st_send;
					end
				end
				st_send: begin
					if (tx_complete) begin
						state <= st_wait_resp;
					end
				end
				st_wait_resp: begin
					if (timed_out) begin
						data_timeout <= 1'b1;
						state        <= st_done;
					end else if (rx_complete) begin
						started <= 1'b0;
						// a rejected token ends the transfer without timeout
						if (rx_frame.tok.token != resp_accepted || last_blk) begin
							state <= st_done;
						end else begin
							blk_left <= blk_left - 1'b1;
							state    <= st_fetch;
						end
					end
				end
				st_recv: begin
					if (timed_out) begin
						data_timeout <= 1'b1;
						state        <= st_done;
					end else if (rx_complete) begin
						started <= 1'b0;
						state   <= st_store;
					end
				end
				st_store: begin
					if (last_blk) begin
						state <= st_done;
					end else begin
						blk_left <= blk_left - 1'b1;
						state    <= st_recv;
					end
				end
				st_done: begin
					if (ack_in) begin
						data_timeout <= 1'b0;
						state        <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// outgoing word, captured with the FIFO pop
	always_ff @(posedge sd_clock) begin
		if (read_enable) begin
			tx_word <= data_from_fifo;
		end
	end

endmodule

// ==== dat_phys.sv ====
// one-bit SD data PHY, one 32-bit word per block; dat_pin needs an external pull-up
`timescale 1ns/10ps

module dat_phys
	import sd_frame_pkg::*, sd_ctrl_pkg::*;
(
	input  logic                 sd_clock,
	input  logic                 rst_n,
	// host
	input  logic                 strobe_in,
	input  logic                 ack_in,
	input  logic                 idle_in,
	input  logic [timeout_w-1:0] timeout_reg,
	input  logic [blk_w-1:0]     blocks,
	input  logic                 write_read,
	input  logic                 multiple,
	output logic                 serial_ready,
	output logic                 complete,
	output logic                 ack_out,
	output logic                 data_timeout,
	// card pin
	inout  wire                  dat_pin,
	// FIFO
	output logic                 read_enable,
	output logic [data_w-1:0]    data_to_fifo,
	output logic                 write_enable,
	input  logic                 status,
	input  logic [data_w-1:0]    data_from_fifo
);

	logic              load_send;
	logic [data_w-1:0] tx_word;
	logic              tx_enable;
	logic              tx_complete;
	logic              tx_bit;
	logic              drive_pin;
	logic              rx_bit;
	logic              rx_enable;
	logic              expect_resp;
	logic              rx_complete;
	logic              start_seen;
	rx_frame_t         rx_frame;

	dat_phys_controller i_ctrl (
		.sd_clock       (sd_clock),
		.rst_n          (rst_n),
		.strobe_in      (strobe_in),
		.ack_in         (ack_in),
		.idle_in        (idle_in),
		.timeout_reg    (timeout_reg),
		.blocks         (blocks),
		.write_read     (write_read),
		.multiple       (multiple),
		.status         (status),
		.data_from_fifo (data_from_fifo),
		.tx_complete    (tx_complete),
		.rx_complete    (rx_complete),
		.start_seen     (start_seen),
		.rx_frame       (rx_frame),
		.serial_ready   (serial_ready),
		.complete       (complete),
		.ack_out        (ack_out),
		.data_timeout   (data_timeout),
		.read_enable    (read_enable),
		.write_enable   (write_enable),
		.data_to_fifo   (data_to_fifo),
		.load_send      (load_send),
		.tx_word        (tx_word),
		.tx_enable      (tx_enable),
		.rx_enable      (rx_enable),
		.expect_resp    (expect_resp),
		.drive_pin      (drive_pin)
	);

	dat_serializer i_ser (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.tx_enable   (tx_enable),
		.load_send   (load_send),
		.tx_word     (tx_word),
		.tx_bit      (tx_bit),
		.tx_complete (tx_complete)
	);

	dat_deserializer i_des (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.rx_enable   (rx_enable),
		.expect_resp (expect_resp),
		.rx_bit      (rx_bit),
		.rx_frame    (rx_frame),
		.rx_complete (rx_complete),
		.start_seen  (start_seen)
	);

	dat_pad i_pad (
		.sd_clock  (sd_clock),
		.rst_n     (rst_n),
		.tx_bit    (tx_bit),
		.drive_pin (drive_pin),
		.rx_bit    (rx_bit),
		.dat_pin   (dat_pin)
	);

endmodule

// ==== dat_phys_assertions.sv ====
// checks host, FIFO and pin rules at the dat_phys boundary; an X on dat_pin means two drivers clash
`timescale 1ns/10ps

module dat_phys_assertions (
	input logic sd_clock,
	input logic rst_n,
	input logic strobe_in,
	input logic ack_in,
	input logic idle_in,
	input logic serial_ready,
	input logic ack_out,
	input logic complete,
	input logic read_enable,
	input logic status,
	input logic drive_pin,
	input logic dat_pin
);

	// failures so far, read by the testbench after each test
	int unsigned fail_count = 0;

	// no pop from an empty FIFO
	read_needs_word: assert property (@(posedge sd_clock) disable iff (!rst_n)
		read_enable |-> status)
	else begin
		$error("read_enable high while the FIFO is empty");
		fail_count++;
	end

	ack_after_strobe: assert property (@(posedge sd_clock) disable iff (!rst_n)
		strobe_in && serial_ready && !idle_in |=> ack_out)
	else begin
		$error("no ack_out one cycle after an accepted strobe");
		fail_count++;
	end

	ack_only_after_strobe: assert property (@(posedge sd_clock) disable iff (!rst_n)
		ack_out |-> $past(strobe_in && serial_ready && !idle_in))
	else begin
		$error("ack_out without an accepted strobe");
		fail_count++;
	end

	// abort may drop it early
	complete_held: assert property (@(posedge sd_clock) disable iff (!rst_n)
		complete && !ack_in && !idle_in |=> complete)
	else begin
		$error("complete dropped before ack_in");
		fail_count++;
	end

	// pad lets go one cycle after drive_pin falls, so the card never fights it
	pin_released: assert property (@(posedge sd_clock) disable iff (!rst_n)
		!drive_pin |=> !$isunknown(dat_pin))
	else begin
		$error("dat_pin driven while drive_pin is low");
		fail_count++;
	end

endmodule

// ==== tb_dat_phys.sv ====
// card model answers each write after a fixed gap; read frames come 3 to 20 cycles apart
`timescale 1ns/10ps

module tb_dat_phys;

	localparam logic [2:0] tok_ok  = 3'b010;
	localparam logic [2:0] tok_bad = 3'b011;
	// tests need under 1000 cycles, worst read gaps included, so 4000 leaves ample room
	localparam int cycle_limit = 4000;

	logic        sd_clock = 1'b0;
	logic        rst_n = 1'b0;
	logic        strobe_in = 1'b0;
	logic        ack_in = 1'b0;
	logic        idle_in = 1'b0;
	logic [15:0] timeout_reg = 16'd200;
	logic [3:0]  blocks = 4'd1;
	logic        write_read = 1'b0;
	logic        multiple = 1'b0;
	logic        status = 1'b0;
	logic [31:0] data_from_fifo = '0;
	logic        serial_ready;
	logic        complete;
	logic        ack_out;
	logic        data_timeout;
	logic        read_enable;
	logic        write_enable;
	logic [31:0] data_to_fifo;
	wire         dat_pin;
	logic        card_oe = 1'b0;
	logic        card_out = 1'b1;
	logic        card_listen = 1'b0;
	logic        pop_pending = 1'b0;
	int          reject_at = -1;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          err_mark = 0;
	int          pops = 0;
	logic [31:0] fifo_q[$];
	logic [31:0] stored[$];
	logic [31:0] words[$];
	logic [49:0] frames[$];

	dat_phys i_dut (.*);

	bind dat_phys dat_phys_assertions i_assert (.*);

	pullup (dat_pin);
	assign dat_pin = card_oe ? card_out : 1'bz;

	initial begin
		forever #50 sd_clock = ~sd_clock;
	end

	always @(posedge sd_clock) begin
		cycles++;
		if (cycles == cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// FIFO model, pop seen at the clock edge, word leaves at the next falling edge
	always @(posedge sd_clock) begin
		pop_pending <= read_enable;
	end

	always @(negedge sd_clock) begin
		if (pop_pending) begin
			void'(fifo_q.pop_front());
			pops++;
		end
		status = (fifo_q.size() != 0);
		data_from_fifo = (fifo_q.size() != 0) ? fifo_q[0] : '0;
		if (write_enable)
			stored.push_back(data_to_fifo);
	end

	// card side of a write: rebuild the frame, then send a token
	always begin : card_rx
		logic [49:0] frame;
		logic [2:0]  tok;
		@(negedge sd_clock);
		if (card_listen && dat_pin === 1'b0) begin
			frame[49] = 1'b0;
			for (int i = 48; i >= 0; i--) begin
				@(negedge sd_clock);
				frame[i] = dat_pin;
			end
			tok = (frames.size() == reject_at) ? tok_bad : tok_ok;
			frames.push_back(frame);
			repeat (4) @(negedge sd_clock);
			for (int i = 2; i >= 0; i--) begin
				card_oe = 1'b1;
				card_out = tok[i];
				@(negedge sd_clock);
			end
			card_oe = 1'b0;
		end
	end

	// start 0, word MSB first, zero trailer, end 1
	function automatic logic [49:0] frame_of(input logic [31:0] word);
		return {1'b0, word, 16'h0000, 1'b1};
	endfunction

	task automatic verify(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("mismatch at %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic send_frame(input logic [31:0] word);
		logic [49:0] frame;
		frame = frame_of(word);
		repeat (3 + $urandom % 18) @(negedge sd_clock);
		for (int i = 49; i >= 0; i--) begin
			card_oe = 1'b1;
			card_out = frame[i];
			@(negedge sd_clock);
		end
		card_oe = 1'b0;
	endtask

	task automatic new_test(input int n);
		frames.delete();
		stored.delete();
		fifo_q.delete();
		words.delete();
		pops = 0;
		repeat (n) words.push_back($urandom);
	endtask

	task automatic start_transfer(input logic wr, input logic multi, input logic [3:0] n);
		@(negedge sd_clock);
		while (!serial_ready) @(negedge sd_clock);
		write_read = wr;
		multiple = multi;
		blocks = n;
		strobe_in = 1'b1;
		@(negedge sd_clock);
		strobe_in = 1'b0;
	endtask

	task automatic await_complete(input logic exp_timeout);
		while (!complete) @(negedge sd_clock);
		verify(data_timeout == exp_timeout,
			$sformatf("data_timeout %b, expected %b", data_timeout, exp_timeout));
		// complete has to stay up until ack_in
		repeat (3) @(negedge sd_clock);
		ack_in = 1'b1;
		@(negedge sd_clock);
		ack_in = 1'b0;
		@(negedge sd_clock);
		verify(serial_ready && !data_timeout, "not back in idle after ack_in");
	endtask

	task automatic report(input string name);
		int errs;
		errs = errors + i_dut.i_assert.fail_count;
		tests++;
		$display("test %0d %s: %s", tests, name, (errs == err_mark) ? "passed" : "failed");
		err_mark = errs;
	endtask

	initial begin
		void'($urandom(68));
		repeat (16) @(posedge sd_clock);
		@(negedge sd_clock);
		rst_n = 1'b1;
		verify(serial_ready && !complete && !ack_out && !data_timeout
			&& !read_enable && !write_enable, "outputs wrong after reset");

		card_listen = 1'b1;
		new_test(1);
		fifo_q = words;
		start_transfer(1'b1, 1'b0, 4'd5);
		await_complete(1'b0);
		verify(frames.size() == 1, $sformatf("%0d frames, expected 1", frames.size()));
		if (frames.size() == 1)
			verify(frames[0] === frame_of(words[0]), $sformatf("frame %h", frames[0]));
		report("single write");

		new_test(4);
		start_transfer(1'b1, 1'b1, 4'd4);
		// controller holds in fetch while the FIFO is empty
		repeat (8) @(negedge sd_clock);
		fifo_q = words;
		await_complete(1'b0);
		verify(frames.size() == 4 && pops == 4,
			$sformatf("%0d frames, %0d pops, expected 4", frames.size(), pops));
		for (int i = 0; i < frames.size() && i < 4; i++)
			verify(frames[i] === frame_of(words[i]), $sformatf("frame %0d %h", i, frames[i]));
		report("multiple write");

		card_listen = 1'b0;
		new_test(3);
		start_transfer(1'b0, 1'b1, 4'd3);
		foreach (words[i])
			send_frame(words[i]);
		await_complete(1'b0);
		verify(stored.size() == 3, $sformatf("%0d words stored, expected 3", stored.size()));
		for (int i = 0; i < stored.size() && i < 3; i++)
			verify(stored[i] === words[i], $sformatf("word %0d %h, expected %h",
				i, stored[i], words[i]));
		report("multiple read");

		// card turns down the second block
		card_listen = 1'b1;
		reject_at = 1;
		new_test(3);
		fifo_q = words;
		start_transfer(1'b1, 1'b1, 4'd3);
		await_complete(1'b0);
		verify(frames.size() == 2 && pops == 2,
			$sformatf("%0d frames, %0d pops, expected 2", frames.size(), pops));
		reject_at = -1;
		report("rejected token");

		card_listen = 1'b0;
		timeout_reg = 16'd40;
		new_test(0);
		start_transfer(1'b0, 1'b0, 4'd1);
		await_complete(1'b1);
		verify(stored.size() == 0, "write_enable during a silent read");
		timeout_reg = 16'd200;
		report("timeout");

		// zero word, so a still driven pin would read low
		new_test(0);
		fifo_q.push_back(32'h0);
		start_transfer(1'b1, 1'b0, 4'd1);
		while (dat_pin !== 1'b0) @(negedge sd_clock);
		repeat (10) @(negedge sd_clock);
		idle_in = 1'b1;
		@(negedge sd_clock);
		idle_in = 1'b0;
		verify(serial_ready, "serial_ready low one cycle after idle_in");
		repeat (2) @(negedge sd_clock);
		repeat (4) begin
			verify(dat_pin === 1'b1, "dat_pin still driven after abort");
			@(negedge sd_clock);
		end
		report("abort");

		$display("tests %0d, checks %0d, value errors %0d, assertion errors %0d",
			tests, checks, errors, i_dut.i_assert.fail_count);
		if (errors == 0 && i_dut.i_assert.fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
sd_frame_pkg.sv
sd_ctrl_pkg.sv
dat_serializer.sv
dat_deserializer.sv
dat_pad.sv
dat_phys_controller.sv
dat_phys.sv
dat_phys_assertions.sv
tb_dat_phys.sv
